/* src/pad_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Pad subsystem package
// Pad count, pad vectors, pad attributes and register port types
//////////////////////////////////////////////////////////////////////

package pad_pkg;

  //////////////////////////////////////////////////////////////////////
  // Pads
  //////////////////////////////////////////////////////////////////////

  parameter int NumPads = 16;

  // One bit per pad, used for in, out and oe
  typedef logic [NumPads-1:0] pad_vec_t;

  // Per-pad attributes
  typedef struct packed {
    logic open_drain;  // Pad only pulls low
    logic invert;      // Flips input and output data
  } pad_attr_t;

  typedef pad_attr_t [NumPads-1:0] pad_attr_vec_t;  // 32 bits for 16 pads

  //////////////////////////////////////////////////////////////////////
  // Register port
  //////////////////////////////////////////////////////////////////////

  typedef logic [31:0] data_t;

  // Register map, one word per register
  typedef enum logic [1:0] {
    ADDR_OUT  = 2'd0,  // Output data
    ADDR_OE   = 2'd1,  // Output enable
    ADDR_IN   = 2'd2,  // Synchronized input, read only
    ADDR_ATTR = 2'd3   // Two attribute bits per pad
  } reg_addr_e;

  // Request, qualified by a separate valid strobe
  typedef struct packed {
    logic      write;
    reg_addr_e addr;
    data_t     wdata;
  } reg_req_t;

  // Response, qualified by a separate valid strobe
  typedef struct packed {
    data_t rdata;
  } reg_rsp_t;

endpackage

/* src/padring.sv */
//////////////////////////////////////////////////////////////////////
// Padring model
// Applies per-pad invert and open-drain, ties off unbonded pads
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module padring #(
  // Bonded pads, the others are tied off
  parameter pad_pkg::pad_vec_t ConnectMask = '1
) (
  // Pad side
  input  pad_pkg::pad_vec_t      pad_in_i,
  output pad_pkg::pad_vec_t      pad_out_o,
  output pad_pkg::pad_vec_t      pad_oe_o,
  // Inner side
  output pad_pkg::pad_vec_t      in_o,
  input  pad_pkg::pad_vec_t      out_i,
  input  pad_pkg::pad_vec_t      oe_i,
  // Pad attributes
  input  pad_pkg::pad_attr_vec_t attr_i
);

  pad_pkg::pad_vec_t out_inv;  // Inner out after inversion

  //////////////////////////////////////////////////////////////////////
  // Per-pad attribute logic
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < pad_pkg::NumPads; i++) begin
      out_inv[i] = out_i[i] ^ attr_i[i].invert;
      if (ConnectMask[i]) begin
        in_o[i] = pad_in_i[i] ^ attr_i[i].invert;
        if (attr_i[i].open_drain) begin
          // Drive low only, release the pad for a 1
          pad_out_o[i] = 1'b0;
          pad_oe_o[i]  = oe_i[i] & ~out_inv[i];
        end else begin
          pad_out_o[i] = out_inv[i];
          pad_oe_o[i]  = oe_i[i];
        end
      end else begin
        in_o[i]      = 1'b0;  // Unbonded pad reads 0
        pad_out_o[i] = 1'b0;
        pad_oe_o[i]  = 1'b0;  // and never drives
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // An enabled open-drain pad means the inner side asked for a low level
  always_comb begin
    for (int i = 0; i < pad_pkg::NumPads; i++) begin
      assert final (!(attr_i[i].open_drain && pad_oe_o[i]) ||
                    (out_i[i] == attr_i[i].invert && !pad_out_o[i]))
        else $error("Open-drain pad %0d enabled while driving high", i);
    end
  end

endmodule

/* src/jtag_overlay_mux.sv */
//////////////////////////////////////////////////////////////////////
// JTAG overlay mux
// Strap pad hands four pads over to JTAG, core sees tie-off values
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module jtag_overlay_mux #(
  parameter int                JtagEnIdx    = 12,
  parameter int                TckIdx       = 8,
  parameter int                TmsIdx       = 9,
  parameter int                TdiIdx       = 10,
  parameter int                TdoIdx       = 11,
  // Core-side input values on the JTAG pads while JTAG owns them
  parameter pad_pkg::pad_vec_t TieOffValues = '0
) (
  input  logic              clk_i,  // Checks only
  input  logic              rst_i,
  // Core side
  input  pad_pkg::pad_vec_t out_core_i,
  input  pad_pkg::pad_vec_t oe_core_i,
  output pad_pkg::pad_vec_t in_core_o,
  // Padring side
  output pad_pkg::pad_vec_t out_padring_o,
  output pad_pkg::pad_vec_t oe_padring_o,
  input  pad_pkg::pad_vec_t in_padring_i,
  // JTAG
  output logic              jtag_tck_o,
  output logic              jtag_tms_o,
  output logic              jtag_tdi_o,
  input  logic              jtag_tdo_i
);

  // Pads taken over by JTAG
  localparam pad_pkg::pad_vec_t JtagMask = pad_pkg::pad_vec_t'(
      (1 << TckIdx) | (1 << TmsIdx) | (1 << TdiIdx) | (1 << TdoIdx));

  logic jtag_en;

  if (JtagEnIdx == TckIdx || JtagEnIdx == TmsIdx || JtagEnIdx == TdiIdx ||
      JtagEnIdx == TdoIdx) begin : gen_strap_idx_err
    $error("JTAG strap pad overlaps a JTAG pad");
  end

  assign jtag_en = in_padring_i[JtagEnIdx];  // Strap, active high

  //////////////////////////////////////////////////////////////////////
  // Overlay
  //////////////////////////////////////////////////////////////////////

  // Inward, JTAG pads replaced by tie-offs
  assign in_core_o = jtag_en ? ((in_padring_i & ~JtagMask) | (TieOffValues & JtagMask))
                             : in_padring_i;

  // Outward
  always_comb begin
    out_padring_o = out_core_i;
    oe_padring_o  = oe_core_i;
    if (jtag_en) begin
      // TCK, TMS and TDI are inputs only
      out_padring_o[TckIdx] = 1'b0;
      out_padring_o[TmsIdx] = 1'b0;
      out_padring_o[TdiIdx] = 1'b0;
      oe_padring_o[TckIdx]  = 1'b0;
      oe_padring_o[TmsIdx]  = 1'b0;
      oe_padring_o[TdiIdx]  = 1'b0;
      out_padring_o[TdoIdx] = jtag_tdo_i;
      oe_padring_o[TdoIdx]  = 1'b1;
    end
  end

  assign jtag_tck_o = jtag_en & in_padring_i[TckIdx];
  assign jtag_tms_o = jtag_en & in_padring_i[TmsIdx];
  assign jtag_tdi_o = jtag_en & in_padring_i[TdiIdx];

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // TDO pad must be driven for as long as the strap is high
  tdo_oe_a: assert property (@(posedge clk_i) disable iff (rst_i)
      in_padring_i[JtagEnIdx] |-> oe_padring_o[TdoIdx])
    else $error("TDO pad not enabled while JTAG is active");

endmodule

/* src/pad_ctrl.sv */
//////////////////////////////////////////////////////////////////////
// Pad control core
// OUT, OE and ATTR registers behind a strobed register port,
// plus a two-flop synchronizer feeding the IN register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module pad_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // Register port
  input  logic                   reg_valid_i,
  input  pad_pkg::reg_req_t      reg_req_i,
  output logic                   rsp_valid_o,
  output pad_pkg::reg_rsp_t      rsp_o,
  // Pads, seen through the overlay mux
  input  pad_pkg::pad_vec_t      in_i,
  output pad_pkg::pad_vec_t      out_o,
  output pad_pkg::pad_vec_t      oe_o,
  output pad_pkg::pad_attr_vec_t attr_o
);

  localparam int AttrW = $bits(pad_pkg::pad_attr_vec_t);

  // Pad registers
  pad_pkg::pad_vec_t      out_q;
  pad_pkg::pad_vec_t      oe_q;
  pad_pkg::pad_attr_vec_t attr_q;

  // Input synchronizer, second stage is the IN register
  pad_pkg::pad_vec_t      in_meta_q;
  pad_pkg::pad_vec_t      in_q;

  // Register port
  logic                   wr_en;
  pad_pkg::data_t         cur_val;   // Addressed register, before the write
  pad_pkg::data_t         new_val;   // Addressed register, after the write
  logic                   rsp_valid_q;
  pad_pkg::reg_rsp_t      rsp_q;

  //////////////////////////////////////////////////////////////////////
  // Input synchronizer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    in_meta_q <= in_i;
    in_q      <= in_meta_q;
  end

  //////////////////////////////////////////////////////////////////////
  // Register writes
  //////////////////////////////////////////////////////////////////////

  assign wr_en = reg_valid_i & reg_req_i.write;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_q  <= '0;
      oe_q   <= '0;
      attr_q <= '0;
    end else if (wr_en) begin
      case (reg_req_i.addr)
        pad_pkg::ADDR_OUT:  out_q  <= reg_req_i.wdata[pad_pkg::NumPads-1:0];
        pad_pkg::ADDR_OE:   oe_q   <= reg_req_i.wdata[pad_pkg::NumPads-1:0];
        pad_pkg::ADDR_ATTR: attr_q <= reg_req_i.wdata[AttrW-1:0];
        default: ;  // IN is read only
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read data and response
  //////////////////////////////////////////////////////////////////////

  // Upper bits of the pad registers read as zero
  always_comb begin
    case (reg_req_i.addr)
      pad_pkg::ADDR_OUT: cur_val = pad_pkg::data_t'(out_q);
      pad_pkg::ADDR_OE:  cur_val = pad_pkg::data_t'(oe_q);
      pad_pkg::ADDR_IN:  cur_val = pad_pkg::data_t'(in_q);
      default:           cur_val = pad_pkg::data_t'(attr_q);
    endcase
  end

  // Write response echoes what the register now holds
  always_comb begin
    case (reg_req_i.addr)
      pad_pkg::ADDR_OUT,
      pad_pkg::ADDR_OE:   new_val = pad_pkg::data_t'(reg_req_i.wdata[pad_pkg::NumPads-1:0]);
      pad_pkg::ADDR_ATTR: new_val = pad_pkg::data_t'(reg_req_i.wdata[AttrW-1:0]);
      default:            new_val = cur_val;  // Write to IN dropped
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= reg_valid_i;  // Every request answered next cycle
    end
  end

  always_ff @(posedge clk_i) begin
    if (reg_valid_i) begin
      rsp_q.rdata <= reg_req_i.write ? new_val : cur_val;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;
  assign out_o       = out_q;
  assign oe_o        = oe_q;
  assign attr_o      = attr_q;

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Response only in the cycle after a request
  rsp_after_req_a: assert property (@(posedge clk_i) disable iff (rst_i)
      rsp_valid_o |-> $past(reg_valid_i))
    else $error("Response without a request");

endmodule

/* src/pad_top.sv */
//////////////////////////////////////////////////////////////////////
// Pad subsystem top
// Padring, JTAG overlay mux and pad control core
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module pad_top #(
  parameter pad_pkg::pad_vec_t ConnectMask  = 16'h3FFF,  // Pads 14, 15 unbonded
  parameter int                JtagEnIdx    = 12,
  parameter int                TckIdx       = 8,
  parameter int                TmsIdx       = 9,
  parameter int                TdiIdx       = 10,
  parameter int                TdoIdx       = 11,
  parameter pad_pkg::pad_vec_t TieOffValues = 16'h0200   // TMS held high
) (
  input  logic              clk_i,
  input  logic              rst_i,
  // Pads
  input  pad_pkg::pad_vec_t pad_in_i,
  output pad_pkg::pad_vec_t pad_out_o,
  output pad_pkg::pad_vec_t pad_oe_o,
  // Register port
  input  logic              reg_valid_i,
  input  pad_pkg::reg_req_t reg_req_i,
  output logic              rsp_valid_o,
  output pad_pkg::reg_rsp_t rsp_o,
  // JTAG
  output logic              jtag_tck_o,
  output logic              jtag_tms_o,
  output logic              jtag_tdi_o,
  input  logic              jtag_tdo_i
);

  pad_pkg::pad_vec_t      out_core, oe_core, in_core;
  pad_pkg::pad_vec_t      out_padring, oe_padring, in_padring;
  pad_pkg::pad_attr_vec_t attr;

  //////////////////////////////////////////////////////////////////////
  // Padring
  //////////////////////////////////////////////////////////////////////

  padring #(
    .ConnectMask ( ConnectMask )
  ) i_padring (
    .pad_in_i  ( pad_in_i    ),
    .pad_out_o ( pad_out_o   ),
    .pad_oe_o  ( pad_oe_o    ),
    .in_o      ( in_padring  ),
    .out_i     ( out_padring ),
    .oe_i      ( oe_padring  ),
    .attr_i    ( attr        )
  );

  //////////////////////////////////////////////////////////////////////
  // JTAG overlay
  //////////////////////////////////////////////////////////////////////

  jtag_overlay_mux #(
    .JtagEnIdx    ( JtagEnIdx    ),
    .TckIdx       ( TckIdx       ),
    .TmsIdx       ( TmsIdx       ),
    .TdiIdx       ( TdiIdx       ),
    .TdoIdx       ( TdoIdx       ),
    .TieOffValues ( TieOffValues )
  ) i_jtag_overlay_mux (
    .clk_i         ( clk_i       ),
    .rst_i         ( rst_i       ),
    .out_core_i    ( out_core    ),
    .oe_core_i     ( oe_core     ),
    .in_core_o     ( in_core     ),
    .out_padring_o ( out_padring ),
    .oe_padring_o  ( oe_padring  ),
    .in_padring_i  ( in_padring  ),
    .jtag_tck_o    ( jtag_tck_o  ),
    .jtag_tms_o    ( jtag_tms_o  ),
    .jtag_tdi_o    ( jtag_tdi_o  ),
    .jtag_tdo_i    ( jtag_tdo_i  )
  );

  //////////////////////////////////////////////////////////////////////
  // Pad control core
  //////////////////////////////////////////////////////////////////////

  pad_ctrl i_pad_ctrl (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .reg_valid_i ( reg_valid_i ),
    .reg_req_i   ( reg_req_i   ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_o       ( rsp_o       ),
    .in_i        ( in_core     ),
    .out_o       ( out_core    ),
    .oe_o        ( oe_core     ),
    .attr_o      ( attr        )
  );

endmodule

/* verification/pad_tb.sv */
//////////////////////////////////////////////////////////////////////
// Pad subsystem testbench
// Directed tests of pad registers, attributes, input sync and JTAG
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module pad_tb;

  localparam pad_pkg::pad_vec_t Mask    = 16'h3FFF;  // Pads 0 to 13 bonded
  localparam pad_pkg::pad_vec_t InvPads = 16'hA00F;  // Pad 15 is unbonded
  localparam pad_pkg::pad_vec_t OdPads  = 16'h00FC;  // Overlaps invert on 2, 3
  localparam int                Timeout = 20;

  logic              clk = 1'b0;
  logic              rst;
  pad_pkg::pad_vec_t pad_in, pad_out, pad_oe;
  logic              reg_valid, rsp_valid;
  pad_pkg::reg_req_t reg_req;
  pad_pkg::reg_rsp_t rsp;
  logic              tck, tms, tdi, tdo;
  int                errors   = 0;
  int                timeouts = 0;

  pad_top #(
    .ConnectMask  ( Mask     ),
    .TieOffValues ( 16'h0200 )
  ) i_pad_top (
    .clk_i       ( clk       ),
    .rst_i       ( rst       ),
    .pad_in_i    ( pad_in    ),
    .pad_out_o   ( pad_out   ),
    .pad_oe_o    ( pad_oe    ),
    .reg_valid_i ( reg_valid ),
    .reg_req_i   ( reg_req   ),
    .rsp_valid_o ( rsp_valid ),
    .rsp_o       ( rsp       ),
    .jtag_tck_o  ( tck       ),
    .jtag_tms_o  ( tms       ),
    .jtag_tdi_o  ( tdi       ),
    .jtag_tdo_i  ( tdo       )
  );

  always #10 clk = ~clk;  // 20 ns period

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_pad_vec(string what, pad_pkg::pad_vec_t got, pad_pkg::pad_vec_t exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_data(string what, pad_pkg::data_t got, pad_pkg::data_t exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(string what, logic got, logic exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Register and pad access
  //////////////////////////////////////////////////////////////////////

  task automatic access_reg(logic wr, pad_pkg::reg_addr_e addr, pad_pkg::data_t wdata,
                            output pad_pkg::data_t rdata);
    int n;
    @(posedge clk);
    reg_valid     <= 1'b1;
    reg_req.write <= wr;
    reg_req.addr  <= addr;
    reg_req.wdata <= wdata;
    @(posedge clk);
    reg_valid <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);  // Sample away from the active edge
      n++;
    end while (!rsp_valid && n < Timeout);
    rdata = rsp.rdata;
    if (!rsp_valid) begin
      timeouts++;
      $display("Register response never arrived within %0d cycles", Timeout);
    end
  endtask

  // Write response echoes the register contents, pad registers are 16 bits
  task automatic reg_write(pad_pkg::reg_addr_e addr, pad_pkg::data_t wdata);
    pad_pkg::data_t rd;
    access_reg(1'b1, addr, wdata, rd);
    if (addr == pad_pkg::ADDR_ATTR) check_data("ATTR write response", rd, wdata);
    else check_data("Pad register write response", rd, wdata & 32'hFFFF);
  endtask

  task automatic reg_read(pad_pkg::reg_addr_e addr, output pad_pkg::data_t rdata);
    access_reg(1'b0, addr, '0, rdata);
  endtask

  task automatic drive_pads(pad_pkg::pad_vec_t pin, logic tdo_v);
    @(posedge clk);
    pad_in <= pin;
    tdo    <= tdo_v;
    @(negedge clk);
  endtask

  // IN goes through two synchronizer flops
  task automatic poll_in(pad_pkg::pad_vec_t exp);
    pad_pkg::data_t rd;
    int n;
    n = 0;
    do begin
      reg_read(pad_pkg::ADDR_IN, rd);
      n++;
    end while (rd !== pad_pkg::data_t'(exp) && n < Timeout);
    if (rd !== pad_pkg::data_t'(exp)) $display("IN register did not settle in %0d reads", n);
    check_data("IN register", rd, pad_pkg::data_t'(exp));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    pad_pkg::data_t rd;
    reg_read(pad_pkg::ADDR_OUT, rd);
    check_data("OUT after reset", rd, '0);
    reg_read(pad_pkg::ADDR_OE, rd);
    check_data("OE after reset", rd, '0);
    reg_read(pad_pkg::ADDR_ATTR, rd);
    check_data("ATTR after reset", rd, '0);
    check_pad_vec("pad_oe_o after reset", pad_oe, '0);
    check_bit("jtag_tck_o after reset", tck, 1'b0);
    check_bit("jtag_tms_o after reset", tms, 1'b0);
    check_bit("jtag_tdi_o after reset", tdi, 1'b0);
  endtask

  task automatic test_out_oe();
    pad_pkg::data_t out_v, oe_v, rd;
    out_v = $urandom();
    oe_v  = $urandom() | 32'h0000_C000;  // Try to enable the unbonded pads
    reg_write(pad_pkg::ADDR_OUT, out_v);
    reg_write(pad_pkg::ADDR_OE, oe_v);
    reg_read(pad_pkg::ADDR_OUT, rd);
    check_data("OUT readback", rd, out_v & 32'hFFFF);
    reg_read(pad_pkg::ADDR_OE, rd);
    check_data("OE readback", rd, oe_v & 32'hFFFF);
    check_pad_vec("pad_out_o", pad_out, out_v[15:0] & Mask);
    check_pad_vec("pad_oe_o", pad_oe, oe_v[15:0] & Mask);
    check_bit("pad 14 oe", pad_oe[14], 1'b0);
    check_bit("pad 15 oe", pad_oe[15], 1'b0);
  endtask

  task automatic test_attr();
    pad_pkg::pad_attr_vec_t attr;
    pad_pkg::pad_vec_t      out_v, oe_v, pin;
    out_v = pad_pkg::pad_vec_t'($urandom());
    oe_v  = pad_pkg::pad_vec_t'($urandom()) | 16'h00F0;
    pin   = pad_pkg::pad_vec_t'($urandom());
    pin[12] = 1'b0;  // Strap stays low, pad 12 is not inverted
    for (int i = 0; i < pad_pkg::NumPads; i++) begin
      attr[i].invert     = InvPads[i];
      attr[i].open_drain = OdPads[i];
    end
    reg_write(pad_pkg::ADDR_ATTR, pad_pkg::data_t'(attr));
    reg_write(pad_pkg::ADDR_OUT, pad_pkg::data_t'(out_v));
    reg_write(pad_pkg::ADDR_OE, pad_pkg::data_t'(oe_v));
    // Open-drain pads drive 0 and enable only for a low level
    check_pad_vec("pad_out_o with attributes", pad_out, (out_v ^ InvPads) & ~OdPads & Mask);
    check_pad_vec("pad_oe_o with attributes", pad_oe,
                  oe_v & ~(OdPads & (out_v ^ InvPads)) & Mask);
    drive_pads(pin, 1'b0);
    poll_in((pin ^ InvPads) & Mask);
    reg_write(pad_pkg::ADDR_ATTR, '0);
  endtask

  task automatic test_input_sync();
    pad_pkg::pad_vec_t pin;
    repeat (6) begin
      pin = pad_pkg::pad_vec_t'($urandom());
      pin[12] = 1'b0;
      drive_pads(pin, 1'b0);
      poll_in(pin & Mask);
    end
  endtask

  task automatic test_jtag_overlay();
    pad_pkg::pad_vec_t out_v, oe_v, pin;
    logic              tdo_v;
    out_v = pad_pkg::pad_vec_t'($urandom());
    oe_v  = pad_pkg::pad_vec_t'($urandom());
    reg_write(pad_pkg::ADDR_OUT, pad_pkg::data_t'(out_v));
    reg_write(pad_pkg::ADDR_OE, pad_pkg::data_t'(oe_v));
    repeat (4) begin
      pin     = pad_pkg::pad_vec_t'($urandom());
      pin[12] = 1'b1;
      tdo_v   = 1'($urandom());
      drive_pads(pin, tdo_v);
      check_bit("jtag_tck_o", tck, pin[8]);
      check_bit("jtag_tms_o", tms, pin[9]);
      check_bit("jtag_tdi_o", tdi, pin[10]);
      check_bit("TDO pad out", pad_out[11], tdo_v);
      check_pad_vec("pad_oe_o under JTAG", pad_oe, (oe_v & Mask & ~16'h0700) | 16'h0800);
      poll_in((pin & Mask & ~16'h0F00) | 16'h0200);  // TMS tie-off high
    end
    pin[12] = 1'b0;  // Release the strap
    drive_pads(pin, 1'b1);
    check_bit("jtag_tck_o released", tck, 1'b0);
    check_bit("jtag_tms_o released", tms, 1'b0);
    check_bit("jtag_tdi_o released", tdi, 1'b0);
    check_pad_vec("pad_out_o released", pad_out, out_v & Mask);
    check_pad_vec("pad_oe_o released", pad_oe, oe_v & Mask);
    poll_in(pin & Mask);
  endtask

  initial begin
    int seed_draw;
    seed_draw = $urandom(58);
    rst       = 1'b1;
    reg_valid = 1'b0;
    reg_req   = '0;
    pad_in    = '0;
    tdo       = 1'b0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    test_reset();
    test_out_oe();
    test_attr();
    test_input_sync();
    test_jtag_overlay();
    $display("Run finished with %0d value errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
src/pad_pkg.sv
src/padring.sv
src/jtag_overlay_mux.sv
src/pad_ctrl.sv
src/pad_top.sv
verification/pad_tb.sv

/* Bender.yml */
package:
  name: pad_subsystem

sources:
  - files:
      - src/pad_pkg.sv
      - src/padring.sv
      - src/jtag_overlay_mux.sv
      - src/pad_ctrl.sv
      - src/pad_top.sv
  - target: test
    files:
      - verification/pad_tb.sv
